// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = sd_controller_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/sd_clk_rst_gen.sv ====
`timescale 1ns/1ps

module sd_clk_rst_gen #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Release lands on a falling edge
  initial begin
    rst_o = 1'b1;
    #(PERIOD_NS * RST_CYCLES) rst_o = 1'b0;
  end

endmodule

// ==== dv/sd_controller_tb.sv ====
`timescale 1ns/1ps
`include "sd_ctrl_defs.svh"

module sd_controller_tb;

  localparam int BUS_WAIT   = 16;
  localparam int START_WAIT = 64;   // Cycles from start pulse to start bit
  localparam int IDLE_POLLS = 64;
  localparam int GNT_WAIT   = 16;

  typedef enum {OP_WRITE, OP_READ, OP_BD_WRITE, OP_BD_DRAIN, OP_COMMAND, OP_REQUEST} op_t;

  typedef struct {
    op_t                   kind;
    sd_reg_pkg::reg_addr_t addr;
    logic [31:0]           data;
    logic [31:0]           exp;
    logic [15:0]           set;
    bit                    hit;       // Second start while the frame runs
    int                    int_exp;   // -1 leaves int_o unchecked
  } row_t;

  logic                  clk;
  logic                  rst;
  sd_reg_pkg::reg_addr_t wb_adr;
  logic [31:0]           wb_dat_w;
  logic [31:0]           wb_dat_r;
  logic [3:0]            wb_sel;
  logic                  wb_we;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_ack;
  logic                  cmd_req;
  logic [15:0]           cmd_set;
  logic [31:0]           cmd_arg;
  logic                  cmd_gnt;
  sd_bd_pkg::bd_half_t   tx_dat;
  logic                  tx_valid;
  logic                  tx_pop;
  sd_bd_pkg::bd_half_t   rx_dat;
  logic                  rx_valid;
  logic                  rx_pop;
  logic                  sd_clk;
  logic                  cmd;
  logic                  int_line;

  row_t                  rows[$];
  sd_bd_pkg::bd_half_t   tx_q[$];
  sd_bd_pkg::bd_half_t   rx_q[$];
  int                    seed = 32'h6755;
  int                    errors = 0;
  int                    checks = 0;
  int                    cycles = 0;
  int                    cycle_limit = 200;

  sd_clk_rst_gen clk_gen (
    .clk_o(clk),
    .rst_o(rst)
  );

  sd_controller_top dut (
    .wb_clk_i(clk), .wb_rst_i(rst), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
    .wb_adr_i(wb_adr), .wb_sel_i(wb_sel), .wb_we_i(wb_we), .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb), .wb_ack_o(wb_ack), .cmd_req_i(cmd_req), .cmd_set_i(cmd_set),
    .cmd_arg_i(cmd_arg), .cmd_gnt_o(cmd_gnt), .tx_bd_dat_o(tx_dat), .tx_bd_valid_o(tx_valid),
    .tx_bd_pop_i(tx_pop), .rx_bd_dat_o(rx_dat), .rx_bd_valid_o(rx_valid), .rx_bd_pop_i(rx_pop),
    .sd_clk_o(sd_clk), .cmd_o(cmd), .int_o(int_line)
  );

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_half(input string name, input sd_bd_pkg::bd_half_t got,
                            input sd_bd_pkg::bd_half_t exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input sd_bd_pkg::bd_count_t got,
                             input sd_bd_pkg::bd_count_t exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // Long division by x^7 + x^3 + 1
  function automatic logic [6:0] crc7_div(input logic [39:0] msg);
    logic [46:0] rem;
    rem = {msg, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i])
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
    end
    return rem[6:0];
  endfunction

  function automatic int budget_of(input row_t r);
    case (r.kind)
      OP_BD_WRITE: return 8;
      OP_BD_DRAIN: return 4 + r.data;
      OP_COMMAND,
      OP_REQUEST:  return 96 * (`RESET_CLK_DIV + 1) + 100;   // Worst case divider
      default:     return 6;
    endcase
  endfunction

  task automatic add_row(input op_t kind, input sd_reg_pkg::reg_addr_t addr,
                         input logic [31:0] data, input logic [31:0] exp,
                         input logic [15:0] set, input bit hit, input int int_exp);
    row_t r;
    r.kind    = kind;
    r.addr    = addr;
    r.data    = data;
    r.exp     = exp;
    r.set     = set;
    r.hit     = hit;
    r.int_exp = int_exp;
    rows.push_back(r);
  endtask

  task automatic bus_cycle(input logic we, input sd_reg_pkg::reg_addr_t adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    @(negedge clk);
    wb_adr   = adr;
    wb_dat_w = wdat;
    wb_sel   = 4'hF;
    wb_we    = we;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < BUS_WAIT);
    if (!wb_ack) begin
      $display("Bus access to %s was never acknowledged", adr.name());
      errors++;
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input sd_reg_pkg::reg_addr_t adr, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic bus_read(input sd_reg_pkg::reg_addr_t adr, output logic [31:0] rdat);
    bus_cycle(1'b0, adr, 32'h0, rdat);
  endtask

  task automatic write_descriptor(input sd_reg_pkg::reg_addr_t adr);
    logic [31:0] word;
    word = $random(seed);
    bus_write(adr, word);
    // Full FIFO drops both halves
    if (adr == sd_reg_pkg::BD_TX && tx_q.size() <= `BD_DEPTH - 2) begin
      tx_q.push_back(word[15:0]);
      tx_q.push_back(word[31:16]);
    end else if (adr == sd_reg_pkg::BD_RX && rx_q.size() <= `BD_DEPTH - 2) begin
      rx_q.push_back(word[15:0]);
      rx_q.push_back(word[31:16]);
    end
  endtask

  task automatic drain_descriptors(input sd_reg_pkg::reg_addr_t adr, input int n);
    logic                is_tx;
    logic                left;
    sd_bd_pkg::bd_half_t exp_half;
    is_tx = (adr == sd_reg_pkg::BD_TX);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if ((is_tx ? tx_q.size() : rx_q.size()) == 0) begin
        $display("Drain of %s asks for more halves than were written", adr.name());
        errors++;
        break;
      end
      exp_half = is_tx ? tx_q.pop_front() : rx_q.pop_front();
      check_word("bd valid", {31'b0, is_tx ? tx_valid : rx_valid}, 32'h1);
      check_half(is_tx ? "tx_bd_dat_o" : "rx_bd_dat_o", is_tx ? tx_dat : rx_dat, exp_half);
      tx_pop = is_tx;
      rx_pop = !is_tx;
    end
    @(negedge clk);
    tx_pop = 1'b0;
    rx_pop = 1'b0;
    left = is_tx ? (tx_q.size() != 0) : (rx_q.size() != 0);
    check_word(is_tx ? "tx_bd_valid_o" : "rx_bd_valid_o",
               {31'b0, is_tx ? tx_valid : rx_valid}, {31'b0, left});
  endtask

  task automatic capture_frame(output logic [47:0] frame);
    int n;
    frame = '0;
    n = 0;
    while (cmd !== 1'b0 && n < START_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (cmd !== 1'b0) begin
      $display("No start bit on cmd_o within %0d cycles", START_WAIT);
      errors++;
    end else begin
      for (int i = 47; i >= 0; i--) begin
        @(posedge sd_clk);
        frame[i] = cmd;
      end
    end
  endtask

  task automatic request_command(input logic [15:0] set, input logic [31:0] arg);
    int n;
    @(negedge clk);
    cmd_req = 1'b1;
    cmd_set = set;
    cmd_arg = arg;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cmd_gnt && n < GNT_WAIT);
    if (!cmd_gnt) begin
      $display("Command request was never granted");
      errors++;
    end
    cmd_req = 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          n;
    st = 32'h1;
    n = 0;
    while (st[sd_reg_pkg::STAT_BUSY] && n < IDLE_POLLS) begin
      bus_read(sd_reg_pkg::STATUS, st);
      n++;
    end
    check_word("STATUS after frame", st, 32'h0);
  endtask

  task automatic check_frame(input logic [47:0] got, input logic [15:0] set,
                             input logic [31:0] arg);
    logic [47:0] want;
    want = {2'b01, set[13:8], arg, crc7_div({2'b01, set[13:8], arg}), 1'b1};
    check_word("cmd frame [47:16]", got[47:16], want[47:16]);
    check_word("cmd frame [15:0]", {16'b0, got[15:0]}, {16'b0, want[15:0]});
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] rd;
    logic [47:0] frame;
    case (r.kind)
      OP_WRITE: begin
        bus_write(r.addr, r.data);
        if (r.addr == sd_reg_pkg::SOFTWARE && r.data[0]) begin
          tx_q.delete();
          rx_q.delete();
        end
      end
      OP_READ: begin
        bus_read(r.addr, rd);
        if (r.addr == sd_reg_pkg::BD_STATUS) begin
          check_count("BD_STATUS tx free", rd[3:0], r.exp[3:0]);
          check_count("BD_STATUS rx free", rd[11:8], r.exp[11:8]);
        end else begin
          check_word(r.addr.name(), rd, r.exp);
        end
      end
      OP_BD_WRITE: write_descriptor(r.addr);
      OP_BD_DRAIN: drain_descriptors(r.addr, r.data);
      OP_COMMAND: begin
        bus_write(sd_reg_pkg::COMMAND, {16'b0, r.set});
        fork
          capture_frame(frame);
          begin
            bus_write(sd_reg_pkg::ARGUMENT, r.data);
            bus_read(sd_reg_pkg::STATUS, rd);
            check_word("STATUS during frame", rd, 32'h1);
            if (r.hit)
              bus_write(sd_reg_pkg::ARGUMENT, r.data);
          end
        join
        wait_idle();
        check_frame(frame, r.set, r.data);
      end
      OP_REQUEST: begin
        fork
          capture_frame(frame);
          begin
            request_command(r.set, r.data);
            bus_read(sd_reg_pkg::STATUS, rd);
            check_word("STATUS during frame", rd, 32'h1);
          end
        join
        wait_idle();
        check_frame(frame, r.set, r.data);
      end
      default: ;
    endcase
    if (r.int_exp >= 0)
      check_word("int_o", {31'b0, int_line}, 32'(r.int_exp));
  endtask

  task automatic build_table();
    // Fixed and plain registers
    add_row(OP_READ,  sd_reg_pkg::CLOCK_D,     32'h0, 32'(`RESET_CLK_DIV), 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::BLOCK,       32'h0, 32'(`BLOCK_SIZE), 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::POWER,       32'h0, 32'h0F, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::CAPA,        32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::CONTROLLER,  32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::STATUS,      32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_WRITE, sd_reg_pkg::TIMEOUT,     32'hBEEF, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::TIMEOUT,     32'h0, 32'hBEEF, 16'h0, 0, 0);
    add_row(OP_WRITE, sd_reg_pkg::SOFTWARE,    32'hA4, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::SOFTWARE,    32'h0, 32'hA4, 16'h0, 0, 0);
    add_row(OP_WRITE, sd_reg_pkg::CLOCK_D,     32'h2, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::CLOCK_D,     32'h0, 32'h2, 16'h0, 0, 0);
    add_row(OP_WRITE, sd_reg_pkg::NORMAL_ISER, 32'h1, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::NORMAL_ISER, 32'h0, 32'h1, 16'h0, 0, 0);
    add_row(OP_WRITE, sd_reg_pkg::ERROR_ISER,  32'hF0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::ERROR_ISER,  32'h0, 32'hF0, 16'h0, 0, 0);
    add_row(OP_WRITE, sd_reg_pkg::BD_ISER,     32'h2, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,  sd_reg_pkg::BD_ISER,     32'h0, 32'h2, 16'h0, 0, 0);
    // Fill TX, overflow once, drain
    add_row(OP_READ,     sd_reg_pkg::BD_STATUS, 32'h0, 32'h0808, 16'h0, 0, 0);
    add_row(OP_BD_WRITE, sd_reg_pkg::BD_TX,     32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_STATUS, 32'h0, 32'h0806, 16'h0, 0, 0);
    add_row(OP_BD_WRITE, sd_reg_pkg::BD_TX,     32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_BD_WRITE, sd_reg_pkg::BD_TX,     32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_BD_WRITE, sd_reg_pkg::BD_TX,     32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_STATUS, 32'h0, 32'h0800, 16'h0, 0, 0);
    add_row(OP_BD_WRITE, sd_reg_pkg::BD_TX,     32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_ISR,    32'h0, 32'h1, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_STATUS, 32'h0, 32'h0800, 16'h0, 0, 0);
    add_row(OP_BD_DRAIN, sd_reg_pkg::BD_TX,     32'd8, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_STATUS, 32'h0, 32'h0808, 16'h0, 0, 0);
    add_row(OP_WRITE,    sd_reg_pkg::BD_ISR,    32'h1, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_ISR,    32'h0, 32'h0, 16'h0, 0, 0);
    // Commands, interrupts and the collision
    add_row(OP_COMMAND, sd_reg_pkg::ARGUMENT,   32'h1AA, 32'h0, 16'h1100, 1, -1);
    add_row(OP_READ,    sd_reg_pkg::NORMAL_ISR, 32'h0, 32'h1, 16'h0, 0, 1);
    add_row(OP_READ,    sd_reg_pkg::ERROR_ISR,  32'h0, 32'h1, 16'h0, 0, 1);
    add_row(OP_WRITE,   sd_reg_pkg::NORMAL_ISR, 32'h1, 32'h0, 16'h0, 0, -1);
    add_row(OP_READ,    sd_reg_pkg::NORMAL_ISR, 32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_WRITE,   sd_reg_pkg::ERROR_ISR,  32'h1, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,    sd_reg_pkg::ERROR_ISR,  32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_COMMAND, sd_reg_pkg::ARGUMENT,   32'h0, 32'h0, 16'h0000, 0, -1);
    add_row(OP_READ,    sd_reg_pkg::NORMAL_ISR, 32'h0, 32'h1, 16'h0, 0, 1);
    add_row(OP_WRITE,   sd_reg_pkg::NORMAL_ISR, 32'h1, 32'h0, 16'h0, 0, -1);
    add_row(OP_REQUEST, sd_reg_pkg::ARGUMENT,   32'h1234ABCD, 32'h0, 16'h0D00, 0, -1);
    add_row(OP_READ,    sd_reg_pkg::ARGUMENT,   32'h0, 32'h1234ABCD, 16'h0, 0, 1);
    add_row(OP_READ,    sd_reg_pkg::COMMAND,    32'h0, 32'h0D00, 16'h0, 0, 1);
    add_row(OP_WRITE,   sd_reg_pkg::NORMAL_ISR, 32'h1, 32'h0, 16'h0, 0, -1);
    add_row(OP_READ,    sd_reg_pkg::NORMAL_ISR, 32'h0, 32'h0, 16'h0, 0, 0);
    // RX drain, then software flush of both FIFOs
    add_row(OP_BD_WRITE, sd_reg_pkg::BD_TX,     32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_BD_WRITE, sd_reg_pkg::BD_RX,     32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_STATUS, 32'h0, 32'h0606, 16'h0, 0, 0);
    add_row(OP_BD_DRAIN, sd_reg_pkg::BD_RX,     32'd2, 32'h0, 16'h0, 0, 0);
    add_row(OP_BD_WRITE, sd_reg_pkg::BD_RX,     32'h0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_STATUS, 32'h0, 32'h0606, 16'h0, 0, 0);
    add_row(OP_WRITE,    sd_reg_pkg::SOFTWARE,  32'h1, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::BD_STATUS, 32'h0, 32'h0808, 16'h0, 0, 0);
    add_row(OP_BD_DRAIN, sd_reg_pkg::BD_TX,     32'd0, 32'h0, 16'h0, 0, 0);
    add_row(OP_BD_DRAIN, sd_reg_pkg::BD_RX,     32'd0, 32'h0, 16'h0, 0, 0);
    add_row(OP_READ,     sd_reg_pkg::SOFTWARE,  32'h0, 32'h1, 16'h0, 0, 0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run stopped at the limit of %0d cycles, errors so far: %0d", cycle_limit,
               errors);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    wb_adr   = sd_reg_pkg::ARGUMENT;
    wb_dat_w = '0;
    wb_sel   = '0;
    wb_we    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    cmd_req  = 1'b0;
    cmd_set  = '0;
    cmd_arg  = '0;
    tx_pop   = 1'b0;
    rx_pop   = 1'b0;
    build_table();
    foreach (rows[i])
      cycle_limit += budget_of(rows[i]);
    wait (rst === 1'b0);
    @(negedge clk);
    foreach (rows[i])
      run_row(rows[i]);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== include/sd_ctrl_defs.svh ====
`ifndef SD_CTRL_DEFS_SVH
`define SD_CTRL_DEFS_SVH

// Descriptor FIFO geometry
`define RAM_MEM_WIDTH 16
`define BD_DEPTH 8

`define BLOCK_SIZE 512        // Bytes per block
`define RESET_CLK_DIV 8'd4

// Start, transmit, index, argument, CRC7, end
`define CMD_FRAME_BITS 48

`endif

// ==== source/sd_bd_fifo.sv ====
`timescale 1ns/1ps
`include "sd_ctrl_defs.svh"

module sd_bd_fifo (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 push_i,
  input  sd_bd_pkg::bd_half_t  dat_i,
  input  logic                 pop_i,
  input  logic                 flush_i,
  output sd_bd_pkg::bd_half_t  dat_o,
  output logic                 valid_o,
  output sd_bd_pkg::bd_count_t free_o
);

  localparam int AW = $clog2(`BD_DEPTH);

  sd_bd_pkg::bd_half_t  mem [`BD_DEPTH];
  logic [AW-1:0]        wr_ptr;
  logic [AW-1:0]        rd_ptr;
  sd_bd_pkg::bd_count_t count;
  logic                 do_push;
  logic                 do_pop;

  assign valid_o = (count != '0);
  assign free_o  = sd_bd_pkg::bd_count_t'(`BD_DEPTH) - count;
  assign do_push = push_i & (free_o != '0);
  assign do_pop  = pop_i & valid_o;
  assign dat_o   = mem[rd_ptr];

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + AW'(1);
      if (do_pop)  rd_ptr <= rd_ptr + AW'(1);
      case ({do_push, do_pop})
        2'b10:   count <= count + 4'd1;
        2'b01:   count <= count - 4'd1;
        default: ;                        // Both or neither
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (do_push)
      mem[wr_ptr] <= dat_i;
  end

endmodule

// ==== source/sd_bd_pkg.sv ====
`include "sd_ctrl_defs.svh"

package sd_bd_pkg;

  // One half of a 32-bit buffer descriptor
  typedef logic [`RAM_MEM_WIDTH-1:0] bd_half_t;

  typedef logic [3:0] bd_count_t;  // Free entries, 0 to BD_DEPTH

endpackage

// ==== source/sd_cmd_serializer.sv ====
`timescale 1ns/1ps
`include "sd_ctrl_defs.svh"

module sd_cmd_serializer (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        start_i,
  input  logic [5:0]  index_i,
  input  logic [31:0] argument_i,
  input  logic [7:0]  clock_divider_i,
  output logic        sd_clk_o,
  output logic        cmd_o,
  output logic        busy_o,
  output logic        done_o,
  output logic        collision_o
);

  localparam int FRAME_W = `CMD_FRAME_BITS;

  logic [7:0]         div_cnt;
  logic               div_tick;
  logic               fall_tick;
  logic               load;
  logic [5:0]         bits_left;
  logic [39:0]        head;       // Start, transmit, index, argument
  logic [FRAME_W-1:0] frame_sr;

  // x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7(input logic [39:0] data);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = data[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  assign head        = {2'b01, index_i, argument_i};
  assign load        = start_i & ~busy_o;
  assign collision_o = start_i & busy_o;
  assign div_tick    = (div_cnt >= clock_divider_i);
  assign fall_tick   = div_tick & sd_clk_o;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      div_cnt   <= '0;
      sd_clk_o  <= 1'b0;
      cmd_o     <= 1'b1;
      busy_o    <= 1'b0;
      done_o    <= 1'b0;
      bits_left <= '0;
    end else begin
      done_o <= 1'b0;
      if (div_tick) begin
        div_cnt  <= '0;
        sd_clk_o <= ~sd_clk_o;
      end else begin
        div_cnt <= div_cnt + 8'd1;
      end
      if (load) begin
        busy_o    <= 1'b1;
        bits_left <= 6'(FRAME_W);
      end else if (busy_o && fall_tick) begin
        if (bits_left != '0) begin
          cmd_o     <= frame_sr[FRAME_W-1];
          bits_left <= bits_left - 6'd1;
        end else begin
          busy_o <= 1'b0;          // End bit has had its full period
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (load)
      frame_sr <= {head, crc7(head), 1'b1};
    else if (busy_o && fall_tick)
      frame_sr <= {frame_sr[FRAME_W-2:0], 1'b0};
  end

endmodule

// ==== source/sd_controller_top.sv ====
`timescale 1ns/1ps

module sd_controller_top (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic [31:0]           wb_dat_i,
  output logic [31:0]           wb_dat_o,
  input  sd_reg_pkg::reg_addr_t wb_adr_i,
  input  logic [3:0]            wb_sel_i,
  input  logic                  wb_we_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  output logic                  wb_ack_o,
  input  logic                  cmd_req_i,
  input  logic [15:0]           cmd_set_i,
  input  logic [31:0]           cmd_arg_i,
  output logic                  cmd_gnt_o,
  output sd_bd_pkg::bd_half_t   tx_bd_dat_o,
  output logic                  tx_bd_valid_o,
  input  logic                  tx_bd_pop_i,
  output sd_bd_pkg::bd_half_t   rx_bd_dat_o,
  output logic                  rx_bd_valid_o,
  input  logic                  rx_bd_pop_i,
  output logic                  sd_clk_o,
  output logic                  cmd_o,
  output logic                  int_o
);

  logic                 cmd_start, cmd_busy, cmd_done, cmd_collision;
  logic [31:0]          argument;
  logic [5:0]           cmd_index;
  logic [7:0]           clock_divider;
  logic [15:0]          normal_isr, error_isr, normal_isr_clr, error_isr_clr;
  logic [15:0]          normal_iser, error_iser;
  logic [7:0]           bd_isr, bd_isr_clr, bd_iser;
  logic                 tx_push, rx_push, bd_overflow_tx, bd_overflow_rx, bd_flush;
  sd_bd_pkg::bd_half_t  bd_dat;
  sd_bd_pkg::bd_count_t tx_free, rx_free;

  sd_controller_wb wb (
    .wb_clk_i, .wb_rst_i, .wb_dat_i, .wb_adr_i, .wb_sel_i, .wb_we_i, .wb_cyc_i, .wb_stb_i,
    .cmd_req_i, .cmd_set_i, .cmd_arg_i, .cmd_busy_i(cmd_busy),
    .tx_free_i(tx_free), .rx_free_i(rx_free),
    .normal_isr_i(normal_isr), .error_isr_i(error_isr), .bd_isr_i(bd_isr),
    .wb_dat_o, .wb_ack_o, .cmd_gnt_o, .cmd_start_o(cmd_start),
    .argument_o(argument), .cmd_index_o(cmd_index), .clock_divider_o(clock_divider),
    .normal_isr_clr_o(normal_isr_clr), .error_isr_clr_o(error_isr_clr),
    .bd_isr_clr_o(bd_isr_clr), .normal_iser_o(normal_iser), .error_iser_o(error_iser),
    .bd_iser_o(bd_iser), .tx_push_o(tx_push), .rx_push_o(rx_push), .bd_dat_o(bd_dat),
    .bd_overflow_tx_o(bd_overflow_tx), .bd_overflow_rx_o(bd_overflow_rx),
    .bd_flush_o(bd_flush)
  );

  sd_bd_fifo tx_bd (
    .wb_clk_i, .wb_rst_i, .push_i(tx_push), .dat_i(bd_dat), .pop_i(tx_bd_pop_i),
    .flush_i(bd_flush), .dat_o(tx_bd_dat_o), .valid_o(tx_bd_valid_o), .free_o(tx_free)
  );

  sd_bd_fifo rx_bd (
    .wb_clk_i, .wb_rst_i, .push_i(rx_push), .dat_i(bd_dat), .pop_i(rx_bd_pop_i),
    .flush_i(bd_flush), .dat_o(rx_bd_dat_o), .valid_o(rx_bd_valid_o), .free_o(rx_free)
  );

  sd_int_status isr (
    .wb_clk_i, .wb_rst_i, .cmd_done_i(cmd_done), .cmd_collision_i(cmd_collision),
    .bd_overflow_tx_i(bd_overflow_tx), .bd_overflow_rx_i(bd_overflow_rx),
    .normal_isr_clr_i(normal_isr_clr), .error_isr_clr_i(error_isr_clr),
    .bd_isr_clr_i(bd_isr_clr), .normal_iser_i(normal_iser), .error_iser_i(error_iser),
    .bd_iser_i(bd_iser), .normal_isr_o(normal_isr), .error_isr_o(error_isr),
    .bd_isr_o(bd_isr), .int_o
  );

  sd_cmd_serializer ser (
    .wb_clk_i, .wb_rst_i, .start_i(cmd_start), .index_i(cmd_index), .argument_i(argument),
    .clock_divider_i(clock_divider), .sd_clk_o, .cmd_o, .busy_o(cmd_busy),
    .done_o(cmd_done), .collision_o(cmd_collision)
  );

endmodule

// ==== source/sd_controller_wb.sv ====
`timescale 1ns/1ps
`include "sd_ctrl_defs.svh"

module sd_controller_wb (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic [31:0]           wb_dat_i,
  input  sd_reg_pkg::reg_addr_t wb_adr_i,
  input  logic [3:0]            wb_sel_i,
  input  logic                  wb_we_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  cmd_req_i,
  input  logic [15:0]           cmd_set_i,
  input  logic [31:0]           cmd_arg_i,
  input  logic                  cmd_busy_i,
  input  sd_bd_pkg::bd_count_t  tx_free_i,
  input  sd_bd_pkg::bd_count_t  rx_free_i,
  input  logic [15:0]           normal_isr_i,
  input  logic [15:0]           error_isr_i,
  input  logic [7:0]            bd_isr_i,
  output logic [31:0]           wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  cmd_gnt_o,
  output logic                  cmd_start_o,
  output logic [31:0]           argument_o,
  output logic [5:0]            cmd_index_o,
  output logic [7:0]            clock_divider_o,
  output logic [15:0]           normal_isr_clr_o,
  output logic [15:0]           error_isr_clr_o,
  output logic [7:0]            bd_isr_clr_o,
  output logic [15:0]           normal_iser_o,
  output logic [15:0]           error_iser_o,
  output logic [7:0]            bd_iser_o,
  output logic                  tx_push_o,
  output logic                  rx_push_o,
  output sd_bd_pkg::bd_half_t   bd_dat_o,
  output logic                  bd_overflow_tx_o,
  output logic                  bd_overflow_rx_o,
  output logic                  bd_flush_o
);

  logic        bus_access;
  logic        reg_wr;        // Write, before ack
  logic        bd_wr_tx;
  logic        bd_wr_rx;
  logic [1:0]  bd_step;
  logic        bd_room;       // Two free entries seen on edge 1
  logic        bd_push;
  logic        req_take;
  logic [31:0] wr_mask;
  logic [31:0] rd_data;
  logic [31:0] wr_data;
  logic [15:0] cmd_setting_reg;
  logic [7:0]  software_reg;
  logic [15:0] timeout_reg;

  assign bus_access = wb_cyc_i & wb_stb_i;
  assign reg_wr     = bus_access & wb_we_i & ~wb_ack_o;
  assign bd_wr_tx   = reg_wr & (wb_adr_i == sd_reg_pkg::BD_TX);
  assign bd_wr_rx   = reg_wr & (wb_adr_i == sd_reg_pkg::BD_RX);
  assign req_take   = ~bus_access & cmd_req_i & ~cmd_gnt_o;
  assign wr_mask    = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};
  assign wr_data    = (rd_data & ~wr_mask) | (wb_dat_i & wr_mask);

  // Low half on step 1, high half on step 2
  assign bd_push          = bd_room & (bd_step == 2'd1 || bd_step == 2'd2);
  assign tx_push_o        = bd_wr_tx & bd_push;
  assign rx_push_o        = bd_wr_rx & bd_push;
  assign bd_dat_o         = (bd_step == 2'd1) ? wb_dat_i[15:0] : wb_dat_i[31:16];
  assign bd_overflow_tx_o = bd_wr_tx & ~bd_room & (bd_step == 2'd1);
  assign bd_overflow_rx_o = bd_wr_rx & ~bd_room & (bd_step == 2'd1);

  assign normal_isr_clr_o = (reg_wr && wb_adr_i == sd_reg_pkg::NORMAL_ISR) ? wb_dat_i[15:0] : '0;
  assign error_isr_clr_o  = (reg_wr && wb_adr_i == sd_reg_pkg::ERROR_ISR) ? wb_dat_i[15:0] : '0;
  assign bd_isr_clr_o     = (reg_wr && wb_adr_i == sd_reg_pkg::BD_ISR) ? wb_dat_i[7:0] : '0;

  assign cmd_index_o = cmd_setting_reg[13:8];

  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      sd_reg_pkg::ARGUMENT:    rd_data = argument_o;
      sd_reg_pkg::COMMAND:     rd_data = {16'b0, cmd_setting_reg};
      sd_reg_pkg::STATUS:      rd_data[sd_reg_pkg::STAT_BUSY] = cmd_busy_i;
      sd_reg_pkg::CONTROLLER:  rd_data = {16'b0, sd_reg_pkg::CONTROLLER_VALUE};
      sd_reg_pkg::BLOCK:       rd_data = 32'(`BLOCK_SIZE);
      sd_reg_pkg::POWER:       rd_data = {24'b0, sd_reg_pkg::POWER_VALUE};
      sd_reg_pkg::SOFTWARE:    rd_data = {24'b0, software_reg};
      sd_reg_pkg::TIMEOUT:     rd_data = {16'b0, timeout_reg};
      sd_reg_pkg::NORMAL_ISR:  rd_data = {16'b0, normal_isr_i};
      sd_reg_pkg::ERROR_ISR:   rd_data = {16'b0, error_isr_i};
      sd_reg_pkg::NORMAL_ISER: rd_data = {16'b0, normal_iser_o};
      sd_reg_pkg::ERROR_ISER:  rd_data = {16'b0, error_iser_o};
      sd_reg_pkg::CAPA:        rd_data = {16'b0, sd_reg_pkg::CAPA_VALUE};
      sd_reg_pkg::CLOCK_D:     rd_data = {24'b0, clock_divider_o};
      sd_reg_pkg::BD_STATUS:   rd_data = {20'b0, rx_free_i, 4'b0, tx_free_i};
      sd_reg_pkg::BD_ISR:      rd_data = {24'b0, bd_isr_i};
      sd_reg_pkg::BD_ISER:     rd_data = {24'b0, bd_iser_o};
      default:                 rd_data = '0;
    endcase
  end

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wb_ack_o        <= 1'b0;
      cmd_gnt_o       <= 1'b0;
      cmd_start_o     <= 1'b0;
      bd_flush_o      <= 1'b0;
      bd_step         <= 2'd0;
      bd_room         <= 1'b0;
      argument_o      <= '0;
      cmd_setting_reg <= '0;
      software_reg    <= '0;
      timeout_reg     <= '0;
      normal_iser_o   <= '0;
      error_iser_o    <= '0;
      bd_iser_o       <= '0;
      clock_divider_o <= `RESET_CLK_DIV;
    end else begin
      // Descriptor writes ack on step 3, all else at once
      wb_ack_o    <= bus_access & ~wb_ack_o & (~(bd_wr_tx | bd_wr_rx) | bd_step == 2'd3);
      cmd_gnt_o   <= req_take;
      cmd_start_o <= req_take | (reg_wr & wb_adr_i == sd_reg_pkg::ARGUMENT);
      bd_flush_o  <= reg_wr & (wb_adr_i == sd_reg_pkg::SOFTWARE) & wr_data[0];
      if (bd_wr_tx | bd_wr_rx) begin
        bd_step <= bd_step + 2'd1;
        if (bd_step == 2'd0)
          bd_room <= ((bd_wr_tx ? tx_free_i : rx_free_i) >= 4'd2);
      end
      if (req_take) begin
        cmd_setting_reg <= cmd_set_i;
        argument_o      <= cmd_arg_i;
      end
      if (reg_wr) begin
        case (wb_adr_i)
          sd_reg_pkg::ARGUMENT:    argument_o      <= wr_data;
          sd_reg_pkg::COMMAND:     cmd_setting_reg <= wr_data[15:0];
          sd_reg_pkg::SOFTWARE:    software_reg    <= wr_data[7:0];
          sd_reg_pkg::TIMEOUT:     timeout_reg     <= wr_data[15:0];
          sd_reg_pkg::NORMAL_ISER: normal_iser_o   <= wr_data[15:0];
          sd_reg_pkg::ERROR_ISER:  error_iser_o    <= wr_data[15:0];
          sd_reg_pkg::BD_ISER:     bd_iser_o       <= wr_data[7:0];
          sd_reg_pkg::CLOCK_D:     clock_divider_o <= wr_data[7:0];
          default: ;
        endcase
      end
    end
  end

  // Read data lands with the ack
  always_ff @(posedge wb_clk_i) begin
    if (bus_access & ~wb_ack_o)
      wb_dat_o <= rd_data;
  end

endmodule

// ==== source/sd_int_status.sv ====
`timescale 1ns/1ps

module sd_int_status (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        cmd_done_i,
  input  logic        cmd_collision_i,
  input  logic        bd_overflow_tx_i,
  input  logic        bd_overflow_rx_i,
  input  logic [15:0] normal_isr_clr_i,
  input  logic [15:0] error_isr_clr_i,
  input  logic [7:0]  bd_isr_clr_i,
  input  logic [15:0] normal_iser_i,
  input  logic [15:0] error_iser_i,
  input  logic [7:0]  bd_iser_i,
  output logic [15:0] normal_isr_o,
  output logic [15:0] error_isr_o,
  output logic [7:0]  bd_isr_o,
  output logic        int_o
);

  logic [15:0] normal_set;
  logic [15:0] error_set;
  logic [7:0]  bd_set;

  always_comb begin
    normal_set = '0;
    error_set  = '0;
    bd_set     = '0;
    normal_set[sd_reg_pkg::ISR_CMD_DONE]     = cmd_done_i;
    error_set[sd_reg_pkg::ISR_CMD_COLLISION] = cmd_collision_i;
    bd_set[sd_reg_pkg::BD_ISR_TX_OVF]        = bd_overflow_tx_i;
    bd_set[sd_reg_pkg::BD_ISR_RX_OVF]        = bd_overflow_rx_i;
  end

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      normal_isr_o <= '0;
      error_isr_o  <= '0;
      bd_isr_o     <= '0;
      int_o        <= 1'b0;
    end else begin
      // New events beat a clear in the same cycle
      normal_isr_o <= (normal_isr_o & ~normal_isr_clr_i) | normal_set;
      error_isr_o  <= (error_isr_o & ~error_isr_clr_i) | error_set;
      bd_isr_o     <= (bd_isr_o & ~bd_isr_clr_i) | bd_set;
      int_o        <= (|(normal_isr_o & normal_iser_i)) | (|(error_isr_o & error_iser_i)) |
                      (|(bd_isr_o & bd_iser_i));
    end
  end

endmodule

// ==== source/sd_reg_pkg.sv ====
package sd_reg_pkg;

  typedef enum logic [7:0] {
    ARGUMENT    = 8'h00,
    COMMAND     = 8'h04,
    STATUS      = 8'h08,
    CONTROLLER  = 8'h1C,
    BLOCK       = 8'h20,
    POWER       = 8'h24,
    SOFTWARE    = 8'h28,
    TIMEOUT     = 8'h2C,
    NORMAL_ISR  = 8'h30,
    ERROR_ISR   = 8'h34,
    NORMAL_ISER = 8'h38,
    ERROR_ISER  = 8'h3C,
    CAPA        = 8'h48,
    CLOCK_D     = 8'h4C,
    BD_STATUS   = 8'h50,
    BD_ISR      = 8'h54,
    BD_ISER     = 8'h58,
    BD_RX       = 8'h60,
    BD_TX       = 8'h80
  } reg_addr_t;

  localparam logic [7:0]  POWER_VALUE      = 8'h0F;    // 3.3 V
  localparam logic [15:0] CAPA_VALUE       = 16'h0000;
  localparam logic [15:0] CONTROLLER_VALUE = 16'h0000; // 1-bit bus

  localparam int STAT_BUSY         = 0;
  localparam int ISR_CMD_DONE      = 0;
  localparam int ISR_CMD_COLLISION = 0;
  localparam int BD_ISR_TX_OVF     = 0;
  localparam int BD_ISR_RX_OVF     = 1;

endpackage

// ==== verilog.f ====
+incdir+include
source/sd_reg_pkg.sv
source/sd_bd_pkg.sv
source/sd_bd_fifo.sv
source/sd_int_status.sv
source/sd_cmd_serializer.sv
source/sd_controller_wb.sv
source/sd_controller_top.sv
dv/sd_clk_rst_gen.sv
dv/sd_controller_tb.sv
